//--- logic/cpu_params.svh
// cpu constants
`default_nettype none
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define CPU_ADDR_W 16
`define CPU_DATA_W 8
`define CPU_REG_NUM 64
`define CPU_REG_AW 6

// first instruction, after the process header and register image
`define CPU_PROG_START (12 + `CPU_REG_NUM)
`define CPU_INSTR_BYTES 4

`endif
`default_nettype wire

//--- logic/cpu_pkg.sv
// cpu shared types
`include "cpu_params.svh"
`default_nettype none

package cpu_pkg;

  typedef enum logic [`CPU_DATA_W-1:0] {
    LOADFROMRAM = 8'd1,
    JUMPMINUS   = 8'd2,
    WRITETORAM  = 8'd3,
    ADD8        = 8'd4,
    JUMPPLUS    = 8'd5,
    ADDNUM8     = 8'd6,
    SET8        = 8'd9
  } opcode_e;

  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_ADDNUM,
    ALU_SET
  } alu_op_e;

  // load is memory to registers
  typedef enum logic {
    XFER_LOAD,
    XFER_STORE
  } xfer_dir_e;

  typedef enum logic [2:0] {
    FD_IDLE,
    FD_FETCH,
    FD_DECODE,
    FD_WAIT_UNIT,
    FD_ADVANCE
  } fetch_state_e;

  typedef enum logic [1:0] {
    UNIT_IDLE,
    UNIT_ACCESS,
    UNIT_WRITE,
    UNIT_DONE
  } unit_state_e;

endpackage

`default_nettype wire

//--- logic/fetch_decode.sv
// instruction fetch and decode
`timescale 1ns/1ps
`include "cpu_params.svh"
`default_nettype none

module fetch_decode
  import cpu_pkg::*;
(
  input  logic                   ram_clk,
  input  logic                   stage3_read,
  output logic                   fetch_req,
  output logic [`CPU_ADDR_W-1:0] fetch_adr,
  input  logic                   bus_done,
  input  logic [`CPU_DATA_W-1:0] bus_rdata,
  output logic                   xfer_start,
  output xfer_dir_e              xfer_dir,
  output logic [`CPU_ADDR_W-1:0] xfer_mem_adr,
  output logic [`CPU_REG_AW-1:0] xfer_reg_start,
  output logic [`CPU_DATA_W-1:0] xfer_len,
  input  logic                   xfer_done,
  output logic                   alu_start,
  output alu_op_e                alu_op,
  output logic [`CPU_REG_AW-1:0] alu_src,
  output logic [`CPU_REG_AW-1:0] alu_dst,
  output logic [`CPU_DATA_W-1:0] alu_len,
  input  logic                   alu_done
);

  fetch_state_e           state;
  logic [1:0]             cnt;
  logic [`CPU_ADDR_W-1:0] pc;
  logic [`CPU_DATA_W-1:0] instr [4];
  opcode_e                opcode;
  logic                   is_jump;
  logic [`CPU_ADDR_W-1:0] jump_dist;

  assign opcode    = opcode_e'(instr[0]);
  assign is_jump   = (opcode == JUMPPLUS) || (opcode == JUMPMINUS);
  // operand counts whole instructions
  assign jump_dist = {{(`CPU_ADDR_W - `CPU_DATA_W - 2){1'b0}}, instr[1], 2'b00};
  assign fetch_adr = pc + {{(`CPU_ADDR_W - 2){1'b0}}, cnt};

  always_ff @(posedge ram_clk or posedge stage3_read) begin
    if (stage3_read) begin
      state      <= FD_IDLE;
      pc         <= `CPU_ADDR_W'(`CPU_PROG_START);
      cnt        <= '0;
      fetch_req  <= 1'b0;
      xfer_start <= 1'b0;
      alu_start  <= 1'b0;
    end else begin
      xfer_start <= 1'b0;
      alu_start  <= 1'b0;
      case (state)
        FD_IDLE: begin
          cnt       <= '0;
          fetch_req <= 1'b1;
          state     <= FD_FETCH;
        end
        FD_FETCH: begin
          if (!fetch_req) begin
            fetch_req <= 1'b1;
          end else if (bus_done) begin
            fetch_req <= 1'b0;
            cnt       <= cnt + 2'd1;
            // jumps stop after the first operand
            if (cnt == 2'd3 || (cnt == 2'd1 && is_jump)) begin
              state <= FD_DECODE;
            end
          end
        end
        FD_DECODE: begin
          case (opcode)
            LOADFROMRAM, WRITETORAM: begin
              xfer_start <= 1'b1;
              state      <= FD_WAIT_UNIT;
            end
            ADD8, ADDNUM8, SET8: begin
              alu_start <= 1'b1;
              state     <= FD_WAIT_UNIT;
            end
            default: state <= FD_ADVANCE;
          endcase
        end
        FD_WAIT_UNIT: begin
          if (xfer_done || alu_done) begin
            pc    <= pc + `CPU_ADDR_W'(`CPU_INSTR_BYTES);
            state <= FD_IDLE;
          end
        end
        FD_ADVANCE: begin
          if (opcode == JUMPPLUS) begin
            pc <= pc + jump_dist;
          end else if (opcode == JUMPMINUS) begin
            pc <= pc - jump_dist;
          end else begin
            pc <= pc + `CPU_ADDR_W'(`CPU_INSTR_BYTES);
          end
          state <= FD_IDLE;
        end
        default: state <= FD_IDLE;
      endcase
    end
  end

  // instruction bytes and unit fields
  always_ff @(posedge ram_clk) begin
    if (state == FD_FETCH && fetch_req && bus_done) begin
      instr[cnt] <= bus_rdata;
    end
    if (state == FD_DECODE) begin
      xfer_dir       <= (opcode == WRITETORAM) ? XFER_STORE : XFER_LOAD;
      xfer_reg_start <= instr[1][`CPU_REG_AW-1:0];
      xfer_len       <= instr[2];
      xfer_mem_adr   <= {{(`CPU_ADDR_W - `CPU_DATA_W){1'b0}}, instr[3]};
      alu_src        <= instr[1][`CPU_REG_AW-1:0];
      if (opcode == SET8) begin
        alu_op  <= ALU_SET;
        alu_dst <= instr[1][`CPU_REG_AW-1:0];
        alu_len <= instr[2];
      end else begin
        alu_op  <= (opcode == ADD8) ? ALU_ADD : ALU_ADDNUM;
        alu_dst <= instr[2][`CPU_REG_AW-1:0];
        alu_len <= instr[3];
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/wb_master.sv
// wishbone classic master
`timescale 1ns/1ps
`include "cpu_params.svh"
`default_nettype none

module wb_master (
  input  logic                   ram_clk,
  input  logic                   stage3_read,
  input  logic                   fetch_req,
  input  logic [`CPU_ADDR_W-1:0] fetch_adr,
  input  logic                   xfer_req,
  input  logic                   xfer_we,
  input  logic [`CPU_ADDR_W-1:0] xfer_adr,
  input  logic [`CPU_DATA_W-1:0] xfer_wdata,
  output logic                   bus_done,
  output logic [`CPU_DATA_W-1:0] bus_rdata,
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output logic [`CPU_ADDR_W-1:0] wb_adr,
  output logic [`CPU_DATA_W-1:0] wb_wdata,
  input  logic [`CPU_DATA_W-1:0] wb_rdata,
  input  logic                   wb_ack
);

  logic active;
  logic can_grant;

  // a requester still holds req while done is high
  assign can_grant = !active && !bus_done;
  assign wb_cyc    = active;
  assign wb_stb    = active;

  always_ff @(posedge ram_clk or posedge stage3_read) begin
    if (stage3_read) begin
      active   <= 1'b0;
      wb_we    <= 1'b0;
      bus_done <= 1'b0;
    end else begin
      bus_done <= 1'b0;
      if (can_grant && fetch_req) begin
        active <= 1'b1;
        wb_we  <= 1'b0;
      end else if (can_grant && xfer_req) begin
        active <= 1'b1;
        wb_we  <= xfer_we;
      end else if (active && wb_ack) begin
        active   <= 1'b0;
        wb_we    <= 1'b0;
        bus_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge ram_clk) begin
    if (can_grant && fetch_req) begin
      wb_adr <= fetch_adr;
    end else if (can_grant && xfer_req) begin
      wb_adr   <= xfer_adr;
      wb_wdata <= xfer_wdata;
    end
    if (active && wb_ack) begin
      bus_rdata <= wb_rdata;
    end
  end

endmodule

`default_nettype wire

//--- logic/register_file.sv
// cpu register file
`timescale 1ns/1ps
`include "cpu_params.svh"
`default_nettype none

module register_file (
  input  logic                   ram_clk,
  input  logic                   stage3_read,
  input  logic                   xfer_we,
  input  logic [`CPU_REG_AW-1:0] xfer_wadr,
  input  logic [`CPU_DATA_W-1:0] xfer_wdata,
  input  logic                   alu_we,
  input  logic [`CPU_REG_AW-1:0] alu_wadr,
  input  logic [`CPU_DATA_W-1:0] alu_wdata,
  input  logic [`CPU_REG_AW-1:0] xfer_radr,
  output logic [`CPU_DATA_W-1:0] xfer_rdata,
  input  logic [`CPU_REG_AW-1:0] alu_radr,
  output logic [`CPU_DATA_W-1:0] alu_rdata
);

  logic [`CPU_DATA_W-1:0] regs [`CPU_REG_NUM];

  // transfer port wins a collision
  always_ff @(posedge ram_clk or posedge stage3_read) begin
    if (stage3_read) begin
      for (int i = 0; i < `CPU_REG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (xfer_we) begin
      regs[xfer_wadr] <= xfer_wdata;
    end else if (alu_we) begin
      regs[alu_wadr] <= alu_wdata;
    end
  end

  assign xfer_rdata = regs[xfer_radr];
  assign alu_rdata  = regs[alu_radr];

endmodule

`default_nettype wire

//--- logic/ram_transfer.sv
// memory to register block copy
`timescale 1ns/1ps
`include "cpu_params.svh"
`default_nettype none

module ram_transfer
  import cpu_pkg::*;
(
  input  logic                   ram_clk,
  input  logic                   stage3_read,
  input  logic                   xfer_start,
  input  xfer_dir_e              xfer_dir,
  input  logic [`CPU_ADDR_W-1:0] xfer_mem_adr,
  input  logic [`CPU_REG_AW-1:0] xfer_reg_start,
  input  logic [`CPU_DATA_W-1:0] xfer_len,
  output logic                   xfer_done,
  output logic                   xfer_req,
  output logic                   xfer_we,
  output logic [`CPU_ADDR_W-1:0] xfer_adr,
  output logic [`CPU_DATA_W-1:0] xfer_wdata,
  input  logic                   bus_done,
  input  logic [`CPU_DATA_W-1:0] bus_rdata,
  output logic                   reg_we,
  output logic [`CPU_REG_AW-1:0] reg_wadr,
  output logic [`CPU_DATA_W-1:0] reg_wdata,
  output logic [`CPU_REG_AW-1:0] reg_radr,
  input  logic [`CPU_DATA_W-1:0] reg_rdata
);

  unit_state_e            state;
  logic [`CPU_DATA_W-1:0] idx;
  logic                   last;

  assign last       = (idx == xfer_len - `CPU_DATA_W'(1));
  // register index wraps at 64
  assign reg_radr   = xfer_reg_start + idx[`CPU_REG_AW-1:0];
  assign reg_wadr   = xfer_reg_start + idx[`CPU_REG_AW-1:0];
  assign reg_wdata  = bus_rdata;
  assign reg_we     = (state == UNIT_WRITE) && (xfer_dir == XFER_LOAD);
  assign xfer_we    = (xfer_dir == XFER_STORE);
  assign xfer_adr   = xfer_mem_adr + {{(`CPU_ADDR_W - `CPU_DATA_W){1'b0}}, idx};
  assign xfer_wdata = reg_rdata;
  assign xfer_done  = (state == UNIT_DONE);

  always_ff @(posedge ram_clk or posedge stage3_read) begin
    if (stage3_read) begin
      state    <= UNIT_IDLE;
      idx      <= '0;
      xfer_req <= 1'b0;
    end else begin
      case (state)
        UNIT_IDLE: begin
          if (xfer_start) begin
            idx <= '0;
            if (xfer_len == '0) begin
              state <= UNIT_DONE;
            end else begin
              xfer_req <= 1'b1;
              state    <= UNIT_ACCESS;
            end
          end
        end
        UNIT_ACCESS: begin
          if (xfer_req && bus_done) begin
            xfer_req <= 1'b0;
            state    <= UNIT_WRITE;
          end
        end
        // load writes the register here, store just steps on
        UNIT_WRITE: begin
          if (last) begin
            state <= UNIT_DONE;
          end else begin
            idx      <= idx + `CPU_DATA_W'(1);
            xfer_req <= 1'b1;
            state    <= UNIT_ACCESS;
          end
        end
        default: state <= UNIT_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/alu_unit.sv
// register range alu
`timescale 1ns/1ps
`include "cpu_params.svh"
`default_nettype none

module alu_unit
  import cpu_pkg::*;
(
  input  logic                   ram_clk,
  input  logic                   stage3_read,
  input  logic                   alu_start,
  input  alu_op_e                alu_op,
  input  logic [`CPU_REG_AW-1:0] alu_src,
  input  logic [`CPU_REG_AW-1:0] alu_dst,
  input  logic [`CPU_DATA_W-1:0] alu_len,
  output logic                   alu_done,
  output logic [`CPU_REG_AW-1:0] reg_radr,
  input  logic [`CPU_DATA_W-1:0] reg_rdata,
  output logic                   reg_we,
  output logic [`CPU_REG_AW-1:0] reg_wadr,
  output logic [`CPU_DATA_W-1:0] reg_wdata
);

  unit_state_e            state;
  logic [`CPU_DATA_W-1:0] idx;
  logic [`CPU_DATA_W-1:0] result;
  logic                   last;

  assign last      = (idx == alu_len - `CPU_DATA_W'(1));
  assign reg_radr  = alu_src + idx[`CPU_REG_AW-1:0];
  assign reg_wadr  = alu_dst + idx[`CPU_REG_AW-1:0];
  assign reg_wdata = result;
  assign reg_we    = (state == UNIT_WRITE);
  assign alu_done  = (state == UNIT_DONE);

  // read in ACCESS, write in WRITE
  always_ff @(posedge ram_clk or posedge stage3_read) begin
    if (stage3_read) begin
      state <= UNIT_IDLE;
      idx   <= '0;
    end else begin
      case (state)
        UNIT_IDLE: begin
          if (alu_start) begin
            idx   <= '0;
            state <= (alu_len == '0) ? UNIT_DONE : UNIT_ACCESS;
          end
        end
        UNIT_ACCESS: state <= UNIT_WRITE;
        UNIT_WRITE: begin
          if (last) begin
            state <= UNIT_DONE;
          end else begin
            idx   <= idx + `CPU_DATA_W'(1);
            state <= UNIT_ACCESS;
          end
        end
        default: state <= UNIT_IDLE;
      endcase
    end
  end

  always_ff @(posedge ram_clk) begin
    if (state == UNIT_ACCESS) begin
      case (alu_op)
        // both operands come from the source range
        ALU_ADD:    result <= reg_rdata + reg_rdata;
        // immediate is the 6-bit source start
        ALU_ADDNUM: result <= reg_rdata + {{(`CPU_DATA_W - `CPU_REG_AW){1'b0}}, alu_src};
        default:    result <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/cpu_top.sv
// cpu top level
`timescale 1ns/1ps
`include "cpu_params.svh"
`default_nettype none

module cpu_top
  import cpu_pkg::*;
(
  input  logic                   ram_clk,
  input  logic                   stage3_read,
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output logic [`CPU_ADDR_W-1:0] wb_adr,
  output logic [`CPU_DATA_W-1:0] wb_wdata,
  input  logic [`CPU_DATA_W-1:0] wb_rdata,
  input  logic                   wb_ack
);

  // bus requests
  logic                   fetch_req;
  logic [`CPU_ADDR_W-1:0] fetch_adr;
  logic                   xfer_req;
  logic                   xfer_we;
  logic [`CPU_ADDR_W-1:0] xfer_adr;
  logic [`CPU_DATA_W-1:0] xfer_wdata;
  logic                   bus_done;
  logic [`CPU_DATA_W-1:0] bus_rdata;

  // dispatch
  logic                   xfer_start;
  xfer_dir_e              xfer_dir;
  logic [`CPU_ADDR_W-1:0] xfer_mem_adr;
  logic [`CPU_REG_AW-1:0] xfer_reg_start;
  logic [`CPU_DATA_W-1:0] xfer_len;
  logic                   xfer_done;
  logic                   alu_start;
  alu_op_e                alu_op;
  logic [`CPU_REG_AW-1:0] alu_src;
  logic [`CPU_REG_AW-1:0] alu_dst;
  logic [`CPU_DATA_W-1:0] alu_len;
  logic                   alu_done;

  // register file ports
  logic                   xfer_reg_we;
  logic [`CPU_REG_AW-1:0] xfer_reg_wadr;
  logic [`CPU_DATA_W-1:0] xfer_reg_wdata;
  logic [`CPU_REG_AW-1:0] xfer_reg_radr;
  logic [`CPU_DATA_W-1:0] xfer_reg_rdata;
  logic                   alu_reg_we;
  logic [`CPU_REG_AW-1:0] alu_reg_wadr;
  logic [`CPU_DATA_W-1:0] alu_reg_wdata;
  logic [`CPU_REG_AW-1:0] alu_reg_radr;
  logic [`CPU_DATA_W-1:0] alu_reg_rdata;

  fetch_decode u_fetch_decode (.*);

  wb_master u_wb_master (.*);

  register_file u_register_file (
    .ram_clk    (ram_clk),
    .stage3_read(stage3_read),
    .xfer_we    (xfer_reg_we),
    .xfer_wadr  (xfer_reg_wadr),
    .xfer_wdata (xfer_reg_wdata),
    .alu_we     (alu_reg_we),
    .alu_wadr   (alu_reg_wadr),
    .alu_wdata  (alu_reg_wdata),
    .xfer_radr  (xfer_reg_radr),
    .xfer_rdata (xfer_reg_rdata),
    .alu_radr   (alu_reg_radr),
    .alu_rdata  (alu_reg_rdata)
  );

  ram_transfer u_ram_transfer (
    .*,
    .reg_we   (xfer_reg_we),
    .reg_wadr (xfer_reg_wadr),
    .reg_wdata(xfer_reg_wdata),
    .reg_radr (xfer_reg_radr),
    .reg_rdata(xfer_reg_rdata)
  );

  alu_unit u_alu_unit (
    .*,
    .reg_radr (alu_reg_radr),
    .reg_rdata(alu_reg_rdata),
    .reg_we   (alu_reg_we),
    .reg_wadr (alu_reg_wadr),
    .reg_wdata(alu_reg_wdata)
  );

endmodule

`default_nettype wire

//--- bench/cpu_sva.sv
// wishbone protocol assertions
`timescale 1ns/1ps
`include "cpu_params.svh"
`default_nettype none

module cpu_sva (
  input logic                   ram_clk,
  input logic                   stage3_read,
  input logic                   wb_cyc,
  input logic                   wb_stb,
  input logic                   wb_we,
  input logic [`CPU_ADDR_W-1:0] wb_adr,
  input logic [`CPU_DATA_W-1:0] wb_wdata,
  input logic                   wb_ack
);

  int stb_fails   = 0;
  int hold_fails  = 0;
  int reset_fails = 0;

  // a cycle ends on the edge after ack and stays idle for one cycle
  cyc_drops_after_ack: assert property (@(posedge ram_clk) disable iff (stage3_read)
    (wb_cyc && wb_stb && wb_ack) |=> (!wb_cyc && !wb_stb))
    else begin
      stb_fails++;
      $error("wb_cyc still high in the cycle after ack");
    end

  // request fields hold until the slave acks
  hold_while_stalled: assert property (@(posedge ram_clk) disable iff (stage3_read)
    (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) && $stable(wb_wdata)))
    else begin
      hold_fails++;
      $error("wishbone request changed before ack");
    end

  idle_in_reset: assert property (@(posedge ram_clk)
    stage3_read |-> !wb_cyc)
    else begin
      reset_fails++;
      $error("wb_cyc high during reset");
    end

endmodule

bind cpu_top cpu_sva i_sva (
  .ram_clk    (ram_clk),
  .stage3_read(stage3_read),
  .wb_cyc     (wb_cyc),
  .wb_stb     (wb_stb),
  .wb_we      (wb_we),
  .wb_adr     (wb_adr),
  .wb_wdata   (wb_wdata),
  .wb_ack     (wb_ack)
);

`default_nettype wire

//--- bench/tb_clock.sv
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic ram_clk,
  output logic stage3_read
);

  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 16;

  initial begin
    ram_clk = 1'b0;
    forever #HALF_PERIOD ram_clk = ~ram_clk;
  end

  // release lands on a falling edge
  initial begin
    stage3_read = 1'b1;
    repeat (RESET_CYCLES) @(posedge ram_clk);
    @(negedge ram_clk);
    stage3_read = 1'b0;
  end

endmodule

`default_nettype wire

//--- bench/tb_checker.sv
// bus reference model and checker
`timescale 1ns/1ps
`include "cpu_params.svh"
`default_nettype none

module tb_checker
  import cpu_pkg::*;
(
  input  logic                   ram_clk,
  input  logic                   stage3_read,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  logic [`CPU_ADDR_W-1:0] wb_adr,
  input  logic [`CPU_DATA_W-1:0] wb_wdata,
  input  logic                   wb_ack,
  input  logic [`CPU_DATA_W-1:0] image [512],
  output logic                   done,
  output int                     errors,
  output int                     checked
);

  logic [`CPU_DATA_W-1:0] ref_mem [512];
  logic [`CPU_DATA_W-1:0] ref_regs [`CPU_REG_NUM];
  logic [`CPU_ADDR_W-1:0] exp_adr [$];
  logic                   exp_we [$];
  logic [`CPU_DATA_W-1:0] exp_data [$];
  int                     exp_total = 0;
  int                     pos = 0;
  int                     err_count = 0;
  logic                   ready = 1'b0;

  assign done    = ready && (pos >= exp_total);
  assign errors  = err_count;
  assign checked = pos;

  function automatic void add_txn(input logic [15:0] adr, input logic we,
                                  input logic [7:0] data);
    exp_adr.push_back(adr);
    exp_we.push_back(we);
    exp_data.push_back(data);
  endfunction

  function automatic logic [7:0] mem_rd(input logic [15:0] adr);
    return ref_mem[adr[8:0]];
  endfunction

  // walks the program image and lists every bus transfer in order
  function automatic int build_expected();
    logic [15:0] pc;
    logic [15:0] adr;
    logic [7:0]  op;
    logic [7:0]  a;
    logic [7:0]  b;
    logic [7:0]  c;
    logic [7:0]  v;
    int          steps;
    bit          spin;
    for (int i = 0; i < 512; i++) begin
      ref_mem[9'(i)] = image[9'(i)];
    end
    for (int i = 0; i < `CPU_REG_NUM; i++) begin
      ref_regs[6'(i)] = '0;
    end
    pc    = `CPU_ADDR_W'(`CPU_PROG_START);
    steps = 0;
    spin  = 1'b0;
    while (!spin && steps < 256) begin
      op = mem_rd(pc);
      a  = mem_rd(pc + 16'd1);
      b  = mem_rd(pc + 16'd2);
      c  = mem_rd(pc + 16'd3);
      add_txn(pc, 1'b0, '0);
      add_txn(pc + 16'd1, 1'b0, '0);
      if (op == JUMPPLUS) begin
        pc = pc + 16'(a) * 16'd4;
      end else if (op == JUMPMINUS) begin
        spin = (a == 8'd0);
        pc   = pc - 16'(a) * 16'd4;
      end else begin
        add_txn(pc + 16'd2, 1'b0, '0);
        add_txn(pc + 16'd3, 1'b0, '0);
        case (op)
          LOADFROMRAM: begin
            for (int i = 0; i < int'(b); i++) begin
              adr = 16'(c) + 16'(i);
              add_txn(adr, 1'b0, '0);
              ref_regs[6'(int'(a) + i)] = mem_rd(adr);
            end
          end
          WRITETORAM: begin
            for (int i = 0; i < int'(b); i++) begin
              adr = 16'(c) + 16'(i);
              v   = ref_regs[6'(int'(a) + i)];
              ref_mem[adr[8:0]] = v;
              add_txn(adr, 1'b1, v);
            end
          end
          ADD8: begin
            for (int i = 0; i < int'(c); i++) begin
              v = ref_regs[6'(int'(a) + i)];
              ref_regs[6'(int'(b) + i)] = v + v;
            end
          end
          ADDNUM8: begin
            // the immediate is the start operand taken as a register index
            for (int i = 0; i < int'(c); i++) begin
              v = ref_regs[6'(int'(a) + i)];
              ref_regs[6'(int'(b) + i)] = v + {2'b00, a[5:0]};
            end
          end
          SET8: begin
            for (int i = 0; i < int'(b); i++) begin
              ref_regs[6'(int'(a) + i)] = '0;
            end
          end
          default: begin
          end
        endcase
        pc = pc + 16'd4;
      end
      steps++;
    end
    return exp_adr.size();
  endfunction

  always @(posedge ram_clk) begin
    if (!stage3_read) begin
      if (!ready) begin
        exp_total = build_expected();
        ready     = 1'b1;
      end
      if (wb_cyc && wb_stb && wb_ack) begin
        if (pos < exp_total) begin
          if (wb_adr !== exp_adr[pos]) begin
            err_count++;
            $display("Mismatch wb_adr: got %h expected %h", wb_adr, exp_adr[pos]);
          end
          if (wb_we !== exp_we[pos]) begin
            err_count++;
            $display("Mismatch wb_we: got %h expected %h", wb_we, exp_we[pos]);
          end else if (wb_we && wb_wdata !== exp_data[pos]) begin
            err_count++;
            $display("Mismatch wb_wdata: got %h expected %h", wb_wdata, exp_data[pos]);
          end
          pos++;
        end else if (wb_we) begin
          err_count++;
          $display("write at address %h after the program should have stopped", wb_adr);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_top.sv
// cpu testbench top
`timescale 1ns/1ps
`include "cpu_params.svh"
`default_nettype none

module tb_top
  import cpu_pkg::*;
();

  localparam int MEM_BYTES    = 512;
  localparam int RESET_LIMIT  = 64;
  localparam int RUN_TIMEOUT  = 20000;
  localparam int QUIET_CYCLES = 200;

  logic                   ram_clk;
  logic                   stage3_read;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  logic [`CPU_ADDR_W-1:0] wb_adr;
  logic [`CPU_DATA_W-1:0] wb_wdata;
  logic [`CPU_DATA_W-1:0] wb_rdata = 8'h00;
  logic                   wb_ack = 1'b0;

  logic [`CPU_DATA_W-1:0] mem [MEM_BYTES];
  logic [15:0]            lfsr_state;
  logic                   pending;
  int                     wait_left;
  logic                   chk_done;
  int                     chk_errors;
  int                     chk_count;

  tb_clock i_clock (
    .ram_clk    (ram_clk),
    .stage3_read(stage3_read)
  );

  cpu_top i_dut (
    .ram_clk    (ram_clk),
    .stage3_read(stage3_read),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_wdata   (wb_wdata),
    .wb_rdata   (wb_rdata),
    .wb_ack     (wb_ack)
  );

  tb_checker i_checker (
    .ram_clk    (ram_clk),
    .stage3_read(stage3_read),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_wdata   (wb_wdata),
    .wb_ack     (wb_ack),
    .image      (mem),
    .done       (chk_done),
    .errors     (chk_errors),
    .checked    (chk_count)
  );

  // galois form, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[6:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  task automatic put_instr(input int at, input logic [7:0] op, input logic [7:0] a,
                           input logic [7:0] b, input logic [7:0] c);
    mem[9'(at)]     = op;
    mem[9'(at + 1)] = a;
    mem[9'(at + 2)] = b;
    mem[9'(at + 3)] = c;
  endtask

  // memory image, then the wishbone slave with random ack delay
  initial begin
    lfsr_state = 16'd44056;
    pending    = 1'b0;
    wait_left  = 0;
    for (int i = 0; i < MEM_BYTES; i++) begin
      mem[9'(i)] = take_bits(8);
    end
    put_instr(76, LOADFROMRAM, 0, 16, 0);
    put_instr(80, WRITETORAM, 0, 16, 170);
    // register range wraps past 63
    put_instr(84, LOADFROMRAM, 60, 10, 20);
    put_instr(88, ADD8, 0, 16, 8);
    put_instr(92, ADDNUM8, 8, 24, 8);
    put_instr(96, SET8, 4, 3, 0);
    put_instr(100, JUMPPLUS, 2, 0, 0);
    put_instr(104, WRITETORAM, 0, 6, 250);
    put_instr(108, 8'd7, 1, 2, 3);
    put_instr(112, WRITETORAM, 60, 40, 186);
    put_instr(116, LOADFROMRAM, 40, 0, 0);
    put_instr(120, JUMPPLUS, 3, 0, 0);
    put_instr(124, SET8, 0, 64, 0);
    put_instr(128, WRITETORAM, 0, 64, 0);
    put_instr(132, WRITETORAM, 16, 16, 226);
    put_instr(136, JUMPPLUS, 3, 0, 0);
    put_instr(140, LOADFROMRAM, 0, 4, 170);
    put_instr(144, JUMPPLUS, 3, 0, 0);
    put_instr(148, JUMPMINUS, 2, 0, 0);
    put_instr(152, SET8, 0, 1, 0);
    put_instr(156, WRITETORAM, 0, 8, 242);
    put_instr(160, JUMPMINUS, 0, 0, 0);
    forever begin
      @(negedge ram_clk);
      if (stage3_read || wb_ack) begin
        wb_ack  = 1'b0;
        pending = 1'b0;
      end else if (wb_cyc && wb_stb) begin
        if (!pending) begin
          pending   = 1'b1;
          wait_left = int'(take_bits(2));
        end
        if (wait_left == 0) begin
          wb_ack = 1'b1;
          if (wb_we) begin
            mem[wb_adr[8:0]] = wb_wdata;
          end else begin
            wb_rdata = mem[wb_adr[8:0]];
          end
        end else begin
          wait_left--;
        end
      end
    end
  end

  initial begin
    int cycles;
    bit timed_out;
    int sva_fails;
    timed_out = 1'b0;
    cycles    = 0;
    do begin
      @(negedge ram_clk);
      cycles++;
    end while (stage3_read !== 1'b0 && cycles < RESET_LIMIT);
    if (stage3_read !== 1'b0) begin
      timed_out = 1'b1;
      $display("timeout: reset was never released");
    end
    if (!timed_out) begin
      cycles = 0;
      while (!chk_done && cycles < RUN_TIMEOUT) begin
        @(negedge ram_clk);
        cycles++;
      end
      if (!chk_done) begin
        timed_out = 1'b1;
        $display("timeout: the program did not reach its final jump");
      end
    end
    // the spin loop must stay free of writes
    if (!timed_out) begin
      for (int i = 0; i < QUIET_CYCLES; i++) begin
        @(negedge ram_clk);
      end
    end
    sva_fails = i_dut.i_sva.stb_fails + i_dut.i_sva.hold_fails + i_dut.i_sva.reset_fails;
    $display("transfers checked %0d, checker errors %0d, assertion failures %0d",
             chk_count, chk_errors, sva_fails);
    if (timed_out || chk_errors != 0 || sva_fails != 0) begin
      $display("Some tests failed");
    end else begin
      $display("All tests passed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+logic
logic/cpu_pkg.sv
logic/fetch_decode.sv
logic/wb_master.sv
logic/register_file.sv
logic/ram_transfer.sv
logic/alu_unit.sv
logic/cpu_top.sv
bench/cpu_sva.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_top.sv

//--- Makefile
# Verilator flow for the cpu testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
